// File: verilog/sys_pkg.sv
package sys_pkg;

	// Major opcode of every SYSTEM instruction.
	localparam logic [6:0] opcode_system = 7'b111_0011;

	// Register forms of the CSR instructions.
	localparam logic [2:0] funct3_csrrw = 3'b001;
	localparam logic [2:0] funct3_csrrs = 3'b010;
	localparam logic [2:0] funct3_csrrc = 3'b011;

	// ECALL, EBREAK, MRET and WFI share this one.
	localparam logic [2:0] funct3_priv = 3'b000;

	// Funct12 field of the privileged forms.
	localparam logic [11:0] imm_ecall = 12'h000;
	localparam logic [11:0] imm_mret = 12'h302;

	// Decoded operation, carried from decode to result.
	typedef enum logic [2:0] {
		op_csrrw,
		op_csrrs,
		op_csrrc,
		op_ecall,
		op_mret,
		op_illegal
	} sys_op_e;

endpackage

// File: verilog/csr_pkg.sv
package csr_pkg;

	// Register width.
	localparam int xlen = 32;

	// Machine trap setup and handling.
	localparam logic [11:0] csr_mie = 12'h304;
	localparam logic [11:0] csr_mtvec = 12'h305;
	localparam logic [11:0] csr_mepc = 12'h341;
	localparam logic [11:0] csr_mcause = 12'h342;
	localparam logic [11:0] csr_mip = 12'h344;

	// Machine information registers, all read as zero.
	localparam logic [11:0] csr_mvendorid = 12'hf11;
	localparam logic [11:0] csr_marchid = 12'hf12;
	localparam logic [11:0] csr_mimpid = 12'hf13;
	localparam logic [11:0] csr_mhartid = 12'hf14;

	// Bit positions shared by MIE and MIP.
	localparam int bit_mtie = 7;
	localparam int bit_msie = 3;

	// Trap causes.
	localparam logic [xlen-1:0] cause_timer_irq = 32'h8000_0007;
	localparam logic [xlen-1:0] cause_ecall_m = 32'h0000_000b;

endpackage

// File: verilog/sys_decode.sv
module sys_decode (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic [31:0] i_instr,
	input logic [csr_pkg::xlen-1:0] i_pc,
	input logic [csr_pkg::xlen-1:0] i_rs1_data,
	output logic o_valid,
	output sys_pkg::sys_op_e o_op,
	output logic [11:0] o_csr_index,
	output logic [4:0] o_rd,
	output logic o_rs1_zero,
	output logic [csr_pkg::xlen-1:0] o_pc,
	output logic [csr_pkg::xlen-1:0] o_operand
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [11:0] funct12;
	logic [4:0] rd;
	logic [4:0] rs1;
	sys_pkg::sys_op_e op_next;

	assign opcode = i_instr[6:0];
	assign rd = i_instr[11:7];
	assign funct3 = i_instr[14:12];
	assign rs1 = i_instr[19:15];
	assign funct12 = i_instr[31:20];

	// Classify the instruction.
	always_comb begin
		op_next = sys_pkg::op_illegal;
		if (opcode == sys_pkg::opcode_system) begin
			case (funct3)
				sys_pkg::funct3_csrrw: op_next = sys_pkg::op_csrrw;
				sys_pkg::funct3_csrrs: op_next = sys_pkg::op_csrrs;
				sys_pkg::funct3_csrrc: op_next = sys_pkg::op_csrrc;
				sys_pkg::funct3_priv: begin
					// Privileged forms need rd and rs1 zero.
					if (rd == 5'd0 && rs1 == 5'd0) begin
						if (funct12 == sys_pkg::imm_ecall)
							op_next = sys_pkg::op_ecall;
						else if (funct12 == sys_pkg::imm_mret)
							op_next = sys_pkg::op_mret;
					end
				end
				default: op_next = sys_pkg::op_illegal;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	// Instruction fields, captured on the strobe.
	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_op <= op_next;
			o_csr_index <= funct12;
			o_rd <= rd;
			o_rs1_zero <= (rs1 == 5'd0);
			o_pc <= i_pc;
			o_operand <= i_rs1_data;
		end
	end

	a_op_known: assert property (@(posedge i_clock) disable iff (i_reset)
		o_valid |-> !$isunknown(o_op));

endmodule

// File: verilog/csr_alu.sv
module csr_alu (
	input sys_pkg::sys_op_e i_op,
	input logic i_rs1_zero,
	input logic [csr_pkg::xlen-1:0] i_old,
	input logic [csr_pkg::xlen-1:0] i_operand,
	output logic o_write,
	output logic [csr_pkg::xlen-1:0] o_new
);

	// Read-modify-write of the addressed CSR.
	always_comb begin
		case (i_op)
			sys_pkg::op_csrrw: begin
				o_new = i_operand;
				o_write = 1'b1;
			end
			sys_pkg::op_csrrs: begin
				o_new = i_old | i_operand;
				// No write at all when rs1 is x0.
				o_write = !i_rs1_zero;
			end
			sys_pkg::op_csrrc: begin
				o_new = i_old & ~i_operand;
				o_write = !i_rs1_zero;
			end
			default: begin
				o_new = i_old;
				o_write = 1'b0;
			end
		endcase
	end

endmodule

// File: verilog/csr_file.sv
module csr_file (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input sys_pkg::sys_op_e i_op,
	input logic [11:0] i_index,
	input logic i_write,
	input logic [csr_pkg::xlen-1:0] i_wdata,
	input logic [csr_pkg::xlen-1:0] i_pc,
	input logic i_timer_irq,
	input logic i_irq_dispatched,
	input logic [csr_pkg::xlen-1:0] i_irq_epc,
	output logic [csr_pkg::xlen-1:0] o_rdata,
	output logic [csr_pkg::xlen-1:0] o_mtvec,
	output logic [csr_pkg::xlen-1:0] o_mepc,
	output logic o_irq_pending,
	output logic [csr_pkg::xlen-1:0] o_irq_pc
);

	logic mie_mtie;
	logic mie_msie;
	logic mip_mtip;
	logic [csr_pkg::xlen-1:0] mtvec;
	logic [csr_pkg::xlen-1:0] mepc;
	logic [csr_pkg::xlen-1:0] mcause;
	logic [csr_pkg::xlen-1:0] mie_word;
	logic [csr_pkg::xlen-1:0] mip_word;
	logic csr_we;
	logic take_ecall;

	assign csr_we = i_valid && i_write;
	assign take_ecall = i_valid && (i_op == sys_pkg::op_ecall);

	assign o_mtvec = mtvec;
	assign o_mepc = mepc;

	// Only the implemented enable and pending bits.
	always_comb begin
		mie_word = '0;
		mie_word[csr_pkg::bit_mtie] = mie_mtie;
		mie_word[csr_pkg::bit_msie] = mie_msie;
		mip_word = '0;
		mip_word[csr_pkg::bit_mtie] = mip_mtip;
	end

	// Read decode. Unknown addresses read zero.
	always_comb begin
		case (i_index)
			csr_pkg::csr_mie: o_rdata = mie_word;
			csr_pkg::csr_mtvec: o_rdata = mtvec;
			csr_pkg::csr_mepc: o_rdata = mepc;
			csr_pkg::csr_mcause: o_rdata = mcause;
			csr_pkg::csr_mip: o_rdata = mip_word;
			csr_pkg::csr_mvendorid: o_rdata = '0;
			csr_pkg::csr_marchid: o_rdata = '0;
			csr_pkg::csr_mimpid: o_rdata = '0;
			csr_pkg::csr_mhartid: o_rdata = '0;
			default: o_rdata = '0;
		endcase
	end

	// Enables and trap vector, written by software only.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mie_mtie <= 1'b0;
			mie_msie <= 1'b0;
			mtvec <= '0;
		end else if (csr_we) begin
			if (i_index == csr_pkg::csr_mie) begin
				mie_mtie <= i_wdata[csr_pkg::bit_mtie];
				mie_msie <= i_wdata[csr_pkg::bit_msie];
			end else if (i_index == csr_pkg::csr_mtvec) begin
				mtvec <= i_wdata;
			end
		end
	end

	// Trap state. Later statements take priority.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mepc <= '0;
			mcause <= '0;
			mip_mtip <= 1'b0;
			o_irq_pending <= 1'b0;
			o_irq_pc <= '0;
		end else begin
			if (csr_we && i_index == csr_pkg::csr_mepc)
				mepc <= i_wdata;
			if (csr_we && i_index == csr_pkg::csr_mcause)
				mcause <= i_wdata;

			// Timer level, gated by MTIE.
			if (i_timer_irq && mie_mtie) begin
				mip_mtip <= 1'b1;
				mcause <= csr_pkg::cause_timer_irq;
				o_irq_pending <= 1'b1;
				o_irq_pc <= mtvec;
			end

			// Dispatch beats a new interrupt.
			if (i_irq_dispatched) begin
				mip_mtip <= 1'b0;
				o_irq_pending <= 1'b0;
				mepc <= i_irq_epc;
			end

			// ECALL owns mepc and mcause.
			if (take_ecall) begin
				mepc <= i_pc;
				mcause <= csr_pkg::cause_ecall_m;
			end
		end
	end

	a_irq_clear: assert property (@(posedge i_clock) disable iff (i_reset)
		$fell(o_irq_pending) |-> $past(i_irq_dispatched) || $past(i_reset));

endmodule

// File: verilog/sys_result.sv
module sys_result (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input sys_pkg::sys_op_e i_op,
	input logic [4:0] i_rd,
	input logic [csr_pkg::xlen-1:0] i_rdata,
	input logic [csr_pkg::xlen-1:0] i_mtvec,
	input logic [csr_pkg::xlen-1:0] i_mepc,
	output logic o_valid,
	output logic o_rd_we,
	output logic [4:0] o_rd,
	output logic [csr_pkg::xlen-1:0] o_rd_data,
	output logic o_redirect,
	output logic [csr_pkg::xlen-1:0] o_redirect_pc,
	output logic o_illegal
);

	logic is_csr;
	logic is_ecall;
	logic is_mret;

	assign is_csr = (i_op == sys_pkg::op_csrrw) || (i_op == sys_pkg::op_csrrs) ||
		(i_op == sys_pkg::op_csrrc);
	assign is_ecall = (i_op == sys_pkg::op_ecall);
	assign is_mret = (i_op == sys_pkg::op_mret);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			o_rd_we <= 1'b0;
			o_redirect <= 1'b0;
			o_illegal <= 1'b0;
		end else begin
			o_valid <= i_valid;
			// x0 is never written back.
			o_rd_we <= i_valid && is_csr && (i_rd != 5'd0);
			o_redirect <= i_valid && (is_ecall || is_mret);
			o_illegal <= i_valid && (i_op == sys_pkg::op_illegal);
		end
	end

	// Writeback data is the CSR value before the write.
	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_rd <= i_rd;
			o_rd_data <= i_rdata;
			o_redirect_pc <= is_ecall ? i_mtvec : i_mepc;
		end
	end

	a_out_valid: assert property (@(posedge i_clock) disable iff (i_reset)
		($rose(o_redirect) || $rose(o_rd_we)) |-> o_valid);

endmodule

// File: verilog/sys_unit.sv
module sys_unit (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic [31:0] i_instr,
	input logic [csr_pkg::xlen-1:0] i_pc,
	input logic [csr_pkg::xlen-1:0] i_rs1_data,
	input logic i_timer_irq,
	input logic i_irq_dispatched,
	input logic [csr_pkg::xlen-1:0] i_irq_epc,
	output logic o_valid,
	output logic o_rd_we,
	output logic [4:0] o_rd,
	output logic [csr_pkg::xlen-1:0] o_rd_data,
	output logic o_redirect,
	output logic [csr_pkg::xlen-1:0] o_redirect_pc,
	output logic o_illegal,
	output logic o_irq_pending,
	output logic [csr_pkg::xlen-1:0] o_irq_pc
);

	// Decode stage outputs.
	logic dec_valid;
	sys_pkg::sys_op_e dec_op;
	logic [11:0] dec_csr_index;
	logic [4:0] dec_rd;
	logic dec_rs1_zero;
	logic [csr_pkg::xlen-1:0] dec_pc;
	logic [csr_pkg::xlen-1:0] dec_operand;

	// Execute stage signals.
	logic [csr_pkg::xlen-1:0] csr_rdata;
	logic [csr_pkg::xlen-1:0] csr_mtvec;
	logic [csr_pkg::xlen-1:0] csr_mepc;
	logic alu_write;
	logic [csr_pkg::xlen-1:0] alu_new;

	sys_decode decode0 (.i_clock, .i_reset, .i_valid, .i_instr, .i_pc, .i_rs1_data,
		.o_valid(dec_valid), .o_op(dec_op), .o_csr_index(dec_csr_index), .o_rd(dec_rd),
		.o_rs1_zero(dec_rs1_zero), .o_pc(dec_pc), .o_operand(dec_operand));

	csr_alu alu0 (.i_op(dec_op), .i_rs1_zero(dec_rs1_zero), .i_old(csr_rdata),
		.i_operand(dec_operand), .o_write(alu_write), .o_new(alu_new));

	csr_file csrs0 (.i_clock, .i_reset, .i_valid(dec_valid), .i_op(dec_op),
		.i_index(dec_csr_index), .i_write(alu_write), .i_wdata(alu_new), .i_pc(dec_pc),
		.i_timer_irq, .i_irq_dispatched, .i_irq_epc, .o_rdata(csr_rdata),
		.o_mtvec(csr_mtvec), .o_mepc(csr_mepc), .o_irq_pending, .o_irq_pc);

	sys_result result0 (.i_clock, .i_reset, .i_valid(dec_valid), .i_op(dec_op),
		.i_rd(dec_rd), .i_rdata(csr_rdata), .i_mtvec(csr_mtvec), .i_mepc(csr_mepc),
		.o_valid, .o_rd_we, .o_rd, .o_rd_data, .o_redirect, .o_redirect_pc, .o_illegal);

endmodule

// File: tb/tb_sys_unit.sv
module tb_sys_unit;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clock_period = 100;
	localparam int reset_cycles = 8;
	localparam int random_count = 400;
	// A random instruction takes at most five cycles with its gap.
	localparam int watchdog_cycles = reset_cycles + 5 * random_count + 200;

	logic i_clock;
	logic i_reset;
	logic i_valid;
	logic [31:0] i_instr;
	logic [csr_pkg::xlen-1:0] i_pc;
	logic [csr_pkg::xlen-1:0] i_rs1_data;
	logic i_timer_irq;
	logic i_irq_dispatched;
	logic [csr_pkg::xlen-1:0] i_irq_epc;
	logic o_valid;
	logic o_rd_we;
	logic [4:0] o_rd;
	logic [csr_pkg::xlen-1:0] o_rd_data;
	logic o_redirect;
	logic [csr_pkg::xlen-1:0] o_redirect_pc;
	logic o_illegal;
	logic o_irq_pending;
	logic [csr_pkg::xlen-1:0] o_irq_pc;

	logic [31:0] lfsr_state;
	logic [31:0] next_pc;

	// Model of the first stage.
	logic s1_valid;
	sys_pkg::sys_op_e s1_op;
	logic [11:0] s1_index;
	logic [4:0] s1_rd;
	logic s1_rs1_zero;
	logic [31:0] s1_pc;
	logic [31:0] s1_operand;

	// Model CSRs and interrupt state.
	logic [31:0] m_mie;
	logic [31:0] m_mtvec;
	logic [31:0] m_mepc;
	logic [31:0] m_mcause;
	logic m_mtip;
	logic m_pending;
	logic [31:0] m_irq_pc;

	// Expected registered outputs.
	logic e_valid;
	logic e_rd_we;
	logic [4:0] e_rd;
	logic [31:0] e_rd_data;
	logic e_redirect;
	logic [31:0] e_redirect_pc;
	logic e_illegal;

	// The nine machine CSRs and one unimplemented address.
	logic [11:0] csr_table [10] = '{csr_pkg::csr_mie, csr_pkg::csr_mtvec, csr_pkg::csr_mepc,
		csr_pkg::csr_mcause, csr_pkg::csr_mip, csr_pkg::csr_mvendorid, csr_pkg::csr_marchid,
		csr_pkg::csr_mimpid, csr_pkg::csr_mhartid, 12'h7c0};

	sys_unit dut0 (.*);

	always #(clock_period / 2) i_clock = ~i_clock;

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at %0t", $time);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			stop_with_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
	endtask

	task automatic check_valid(input logic expected);
		compare_value("o_valid", 32'(o_valid), 32'(expected));
	endtask

	task automatic check_writeback(input logic we, input logic [4:0] rd,
		input logic [csr_pkg::xlen-1:0] data);
		compare_value("o_rd_we", 32'(o_rd_we), 32'(we));
		if (we) begin
			compare_value("o_rd", 32'(o_rd), 32'(rd));
			compare_value("o_rd_data", o_rd_data, data);
		end
	endtask

	task automatic check_redirect(input logic flag, input logic [csr_pkg::xlen-1:0] pc);
		compare_value("o_redirect", 32'(o_redirect), 32'(flag));
		if (flag)
			compare_value("o_redirect_pc", o_redirect_pc, pc);
	endtask

	task automatic check_irq(input logic pending, input logic [csr_pkg::xlen-1:0] pc);
		compare_value("o_irq_pending", 32'(o_irq_pending), 32'(pending));
		if (pending)
			compare_value("o_irq_pc", o_irq_pc, pc);
	endtask

	task automatic check_illegal(input logic flag);
		compare_value("o_illegal", 32'(o_illegal), 32'(flag));
	endtask

	// RV32 SYSTEM decode. Privileged forms need rd and rs1 zero.
	function automatic sys_pkg::sys_op_e classify(input logic [31:0] instr);
		sys_pkg::sys_op_e op;
		op = sys_pkg::op_illegal;
		if (instr[6:0] == sys_pkg::opcode_system) begin
			case (instr[14:12])
				sys_pkg::funct3_csrrw: op = sys_pkg::op_csrrw;
				sys_pkg::funct3_csrrs: op = sys_pkg::op_csrrs;
				sys_pkg::funct3_csrrc: op = sys_pkg::op_csrrc;
				sys_pkg::funct3_priv: begin
					if (instr[19:7] == 13'd0 && instr[31:20] == sys_pkg::imm_ecall)
						op = sys_pkg::op_ecall;
					else if (instr[19:7] == 13'd0 && instr[31:20] == sys_pkg::imm_mret)
						op = sys_pkg::op_mret;
				end
				default: op = sys_pkg::op_illegal;
			endcase
		end
		return op;
	endfunction

	function automatic logic [31:0] model_read(input logic [11:0] index);
		case (index)
			csr_pkg::csr_mie: return m_mie;
			csr_pkg::csr_mtvec: return m_mtvec;
			csr_pkg::csr_mepc: return m_mepc;
			csr_pkg::csr_mcause: return m_mcause;
			csr_pkg::csr_mip: return {24'd0, m_mtip, 7'd0};
			default: return 32'd0;
		endcase
	endfunction

	task automatic reset_model();
		s1_valid = 1'b0;
		e_valid = 1'b0;
		e_rd_we = 1'b0;
		e_redirect = 1'b0;
		e_illegal = 1'b0;
		m_mie = '0;
		m_mtvec = '0;
		m_mepc = '0;
		m_mcause = '0;
		m_mtip = 1'b0;
		m_pending = 1'b0;
		m_irq_pc = '0;
	endtask

	// State after the coming rising edge, from the inputs now driven.
	task automatic advance_model();
		logic [31:0] old_value;
		logic [31:0] new_value;
		logic do_write;
		logic old_mtie;
		logic [31:0] old_mtvec;
		if (i_reset) begin
			reset_model();
		end else begin
			old_value = model_read(s1_index);
			old_mtie = m_mie[csr_pkg::bit_mtie];
			old_mtvec = m_mtvec;
			e_valid = s1_valid;
			e_rd_we = s1_valid && (s1_op inside {sys_pkg::op_csrrw, sys_pkg::op_csrrs,
				sys_pkg::op_csrrc}) && (s1_rd != 5'd0);
			e_redirect = s1_valid && (s1_op == sys_pkg::op_ecall || s1_op == sys_pkg::op_mret);
			e_illegal = s1_valid && (s1_op == sys_pkg::op_illegal);
			e_rd = s1_rd;
			e_rd_data = old_value;
			e_redirect_pc = (s1_op == sys_pkg::op_ecall) ? m_mtvec : m_mepc;
			new_value = old_value;
			do_write = 1'b0;
			case (s1_op)
				sys_pkg::op_csrrw: begin
					new_value = s1_operand;
					do_write = 1'b1;
				end
				sys_pkg::op_csrrs: begin
					new_value = old_value | s1_operand;
					do_write = !s1_rs1_zero;
				end
				sys_pkg::op_csrrc: begin
					new_value = old_value & ~s1_operand;
					do_write = !s1_rs1_zero;
				end
				default: do_write = 1'b0;
			endcase
			if (s1_valid && do_write) begin
				case (s1_index)
					csr_pkg::csr_mie: m_mie = new_value & 32'h0000_0088;
					csr_pkg::csr_mtvec: m_mtvec = new_value;
					csr_pkg::csr_mepc: m_mepc = new_value;
					csr_pkg::csr_mcause: m_mcause = new_value;
				endcase
			end
			if (i_timer_irq && old_mtie) begin
				m_mtip = 1'b1;
				m_mcause = csr_pkg::cause_timer_irq;
				m_pending = 1'b1;
				m_irq_pc = old_mtvec;
			end
			// Dispatch beats the interrupt, ECALL beats both.
			if (i_irq_dispatched) begin
				m_mtip = 1'b0;
				m_pending = 1'b0;
				m_mepc = i_irq_epc;
			end
			if (s1_valid && s1_op == sys_pkg::op_ecall) begin
				m_mepc = s1_pc;
				m_mcause = csr_pkg::cause_ecall_m;
			end
			s1_valid = i_valid;
			if (i_valid) begin
				s1_op = classify(i_instr);
				s1_index = i_instr[31:20];
				s1_rd = i_instr[11:7];
				s1_rs1_zero = (i_instr[19:15] == 5'd0);
				s1_pc = i_pc;
				s1_operand = i_rs1_data;
			end
		end
	endtask

	// One clock cycle, from falling edge to falling edge.
	task automatic run_cycle(input logic valid, input logic [31:0] instr,
		input logic [31:0] pc, input logic [31:0] rs1);
		i_valid = valid;
		i_instr = instr;
		i_pc = pc;
		i_rs1_data = rs1;
		advance_model();
		@(negedge i_clock);
		check_valid(e_valid);
		check_writeback(e_rd_we, e_rd, e_rd_data);
		check_redirect(e_redirect, e_redirect_pc);
		check_illegal(e_illegal);
		check_irq(m_pending, m_irq_pc);
		i_irq_dispatched = 1'b0;
	endtask

	task automatic idle(input int count);
		repeat (count) run_cycle(1'b0, 32'd0, 32'd0, 32'd0);
	endtask

	task automatic issue_word(input logic [31:0] word, input logic [31:0] rs1);
		run_cycle(1'b1, word, next_pc, rs1);
		next_pc = next_pc + 32'd4;
	endtask

	task automatic issue_csr(input logic [2:0] funct3, input logic [11:0] index,
		input logic [4:0] rs1, input logic [4:0] rd, input logic [31:0] operand);
		issue_word({index, rs1, funct3, rd, sys_pkg::opcode_system}, operand);
	endtask

	task automatic issue_priv(input logic [11:0] imm);
		issue_word({imm, 13'd0, sys_pkg::opcode_system}, 32'd0);
	endtask

	// CSRRS with rs1 = x0 only reads.
	task automatic read_csr(input logic [11:0] index);
		issue_csr(sys_pkg::funct3_csrrs, index, 5'd0, 5'd1, rand_bits(32));
	endtask

	task automatic read_all_csrs();
		for (int i = 0; i < 10; i++)
			read_csr(csr_table[i]);
	endtask

	task automatic random_stream(input int count);
		int kind;
		logic [2:0] funct3;
		logic [4:0] rs1;
		logic [31:0] word;
		for (int n = 0; n < count; n++) begin
			kind = int'(rand_bits(4));
			rs1 = 5'(rand_bits(5));
			if (rand_bits(2) == 32'd0)
				rs1 = 5'd0;
			word = rand_bits(32);
			case (kind % 3)
				0: funct3 = sys_pkg::funct3_csrrw;
				1: funct3 = sys_pkg::funct3_csrrs;
				default: funct3 = sys_pkg::funct3_csrrc;
			endcase
			if (kind < 11) begin
				issue_csr(funct3, csr_table[int'(rand_bits(4)) % 10], rs1, 5'(rand_bits(5)),
					rand_bits(32));
			end else if (kind == 11) begin
				issue_priv(sys_pkg::imm_ecall);
			end else if (kind == 12) begin
				issue_priv(sys_pkg::imm_mret);
			end else begin
				// Non-SYSTEM, unused funct3, or random funct12.
				if (kind == 13)
					word[4] = 1'b0;
				else if (kind == 14)
					word[14:0] = {3'b100, word[11:7], sys_pkg::opcode_system};
				else
					word[19:0] = {13'd0, sys_pkg::opcode_system};
				issue_word(word, rand_bits(32));
			end
			if (rand_bits(2) == 32'd0)
				idle(int'(rand_bits(2)) + 1);
		end
	endtask

	initial begin
		#(watchdog_cycles * clock_period);
		stop_with_failure("timeout: the run did not finish within the expected time");
	end

	initial begin
		lfsr_state = 32'hcfda_3672;
		next_pc = 32'h0000_1000;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_instr = '0;
		i_pc = '0;
		i_rs1_data = '0;
		i_timer_irq = 1'b0;
		i_irq_dispatched = 1'b0;
		i_irq_epc = '0;
		@(negedge i_clock);
		idle(reset_cycles);
		i_reset = 1'b0;
		read_all_csrs();

		// Random CSR traffic with ECALL, MRET and illegal words mixed in.
		random_stream(random_count);
		idle(2);

		// ECALL, then read back mepc and mcause.
		issue_csr(sys_pkg::funct3_csrrw, csr_pkg::csr_mtvec, 5'd3, 5'd0, 32'h0000_8000);
		issue_priv(sys_pkg::imm_ecall);
		read_csr(csr_pkg::csr_mepc);
		read_csr(csr_pkg::csr_mcause);

		// MRET right behind its mepc write.
		issue_csr(sys_pkg::funct3_csrrw, csr_pkg::csr_mepc, 5'd4, 5'd0, 32'h0000_2468);
		issue_priv(sys_pkg::imm_mret);

		// addi x0, x0, 0, then funct3 100 and WFI.
		issue_word(32'h0000_0013, 32'd0);
		issue_word({12'h000, 5'd0, 3'b100, 5'd0, sys_pkg::opcode_system}, 32'd0);
		issue_priv(12'h105);

		// Timer held while masked, then enabled.
		issue_csr(sys_pkg::funct3_csrrw, csr_pkg::csr_mie, 5'd1, 5'd0, 32'd0);
		idle(1);
		i_timer_irq = 1'b1;
		idle(3);
		issue_csr(sys_pkg::funct3_csrrw, csr_pkg::csr_mtvec, 5'd5, 5'd0, 32'h0000_4000);
		issue_csr(sys_pkg::funct3_csrrs, csr_pkg::csr_mie, 5'd6, 5'd0, 32'h0000_0080);
		idle(3);
		i_timer_irq = 1'b0;
		idle(2);
		read_csr(csr_pkg::csr_mip);
		read_csr(csr_pkg::csr_mcause);
		i_irq_epc = 32'h0000_3000;
		i_irq_dispatched = 1'b1;
		idle(1);
		read_csr(csr_pkg::csr_mepc);
		read_csr(csr_pkg::csr_mip);

		// Dispatch against a held timer, and ECALL against the interrupt.
		i_timer_irq = 1'b1;
		idle(2);
		i_irq_epc = rand_bits(32);
		i_irq_dispatched = 1'b1;
		issue_priv(sys_pkg::imm_ecall);
		idle(1);
		i_timer_irq = 1'b0;
		read_csr(csr_pkg::csr_mepc);
		read_csr(csr_pkg::csr_mcause);
		read_csr(csr_pkg::csr_mip);

		// Reset in the middle of traffic with the interrupt pending.
		i_timer_irq = 1'b1;
		random_stream(6);
		i_reset = 1'b1;
		random_stream(3);
		i_timer_irq = 1'b0;
		i_reset = 1'b0;
		idle(2);
		read_all_csrs();
		idle(2);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: build.f
verilog/sys_pkg.sv
verilog/csr_pkg.sv
verilog/sys_decode.sv
verilog/csr_alu.sv
verilog/csr_file.sv
verilog/sys_result.sv
verilog/sys_unit.sv
tb/tb_sys_unit.sv

// File: Makefile
# Verilator build and run of the system-instruction unit testbench.
VERILATOR ?= verilator
TOP ?= tb_sys_unit
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
